/* src/text_overlay_pkg.sv */
package text_overlay_pkg;

	//////////////////////////////////////////////////
	// Widths and types
	//////////////////////////////////////////////////
	typedef logic [9:0] coord_t; // Raster coordinate
	typedef logic [3:0] bcd_t; // Above 9 shows blank
	typedef logic [4:0] glyph_t; // Index into 32 glyph table
	typedef logic [3:0] glyph_row_t;
	typedef logic [2:0] glyph_col_t;
	typedef logic [7:0] font_row_t; // MSB is leftmost pixel
	typedef logic [127:0] glyph_bits_t; // 16 rows of 8 pixels, row 0 on top
	typedef logic [11:0] rgb_t; // 4 bits per channel
	typedef logic [2:0] weekday_t; // 0 Monday .. 6 Sunday, 7 none
	typedef logic [1:0] cursor_loc_t; // 0 right, 1 middle, 2 left, 3 off
	typedef logic [3:0] large_band_t; // pixel_y / 64
	typedef logic [4:0] large_cell_t; // pixel_x / 32
	typedef logic [4:0] medium_band_t; // pixel_y / 32
	typedef logic [5:0] medium_cell_t; // pixel_x / 16

	typedef enum logic [1:0] {
		cfg_normal = 2'd0,
		cfg_time = 2'd1,
		cfg_date = 2'd2
	} config_mode_t; // Code 3 falls back to normal

	//////////////////////////////////////////////////
	// Glyph codes
	//////////////////////////////////////////////////
	localparam int GLYPH_COUNT = 32;
	localparam string GLYPH_FILE = "src/glyphs.mem";
	localparam glyph_t G_DIGIT0 = 5'd0; // Digits 0..9 in order
	localparam glyph_t G_COLON = 5'd10;
	localparam glyph_t G_SLASH = 5'd11;
	localparam glyph_t G_BLANK = 5'd12;
	localparam glyph_t G_ARROW = 5'd13; // Up arrow for cursor
	localparam glyph_t G_A = 5'd14;
	localparam glyph_t G_B = 5'd15;
	localparam glyph_t G_C = 5'd16;
	localparam glyph_t G_D = 5'd17;
	localparam glyph_t G_E = 5'd18;
	localparam glyph_t G_G = 5'd19;
	localparam glyph_t G_I = 5'd20;
	localparam glyph_t G_J = 5'd21;
	localparam glyph_t G_L = 5'd22;
	localparam glyph_t G_M = 5'd23;
	localparam glyph_t G_N = 5'd24;
	localparam glyph_t G_O = 5'd25;
	localparam glyph_t G_P = 5'd26;
	localparam glyph_t G_R = 5'd27;
	localparam glyph_t G_S = 5'd28;
	localparam glyph_t G_T = 5'd29;
	localparam glyph_t G_U = 5'd30;
	localparam glyph_t G_V = 5'd31;

	//////////////////////////////////////////////////
	// Layout bands and cells
	//////////////////////////////////////////////////
	localparam large_band_t TIME_BAND = 4'd2; // 32x64 font
	localparam large_cell_t TIME_CELL_FIRST = 5'd7;
	localparam large_cell_t TIME_CELLS = 5'd8;
	localparam medium_band_t AMPM_BAND = 5'd1; // 16x32 font from here on
	localparam medium_cell_t AMPM_CELL_FIRST = 6'd26;
	localparam medium_cell_t AMPM_CELLS = 6'd2;
	localparam medium_band_t DATE_BAND = 5'd11;
	localparam medium_cell_t DATE_CELL_FIRST = 6'd8;
	localparam medium_cell_t DATE_CELLS = 6'd8;
	localparam medium_band_t WDAY_BAND = 5'd13;
	localparam medium_cell_t WDAY_CELL_FIRST = 6'd8;
	localparam medium_cell_t WDAY_CELLS = 6'd9;
	localparam medium_band_t CUR_TIME_BAND = 5'd6; // Under the large digits
	localparam medium_cell_t CUR_TIME_PAIR0 = 6'd26;
	localparam medium_cell_t CUR_TIME_PAIR1 = 6'd20;
	localparam medium_cell_t CUR_TIME_PAIR2 = 6'd14;
	localparam medium_cell_t CUR_TIME_CELLS = 6'd4;
	localparam medium_band_t CUR_DATE_BAND = 5'd12; // Between date and weekday
	localparam medium_cell_t CUR_DATE_PAIR0 = 6'd14;
	localparam medium_cell_t CUR_DATE_PAIR1 = 6'd11;
	localparam medium_cell_t CUR_DATE_PAIR2 = 6'd8;
	localparam medium_cell_t CUR_DATE_CELLS = 6'd2;

	localparam rgb_t COL_WHITE = 12'hFFF;
	localparam rgb_t COL_GREEN = 12'h2F2;
	localparam rgb_t COL_RED = 12'hF11;

	// Digit to glyph, out of range values go blank
	function automatic glyph_t digit_glyph(input bcd_t digit);
		glyph_t g;
		if (digit > 4'd9)
			g = G_BLANK;
		else
			g = G_DIGIT0 + glyph_t'(digit);
		return g;
	endfunction

endpackage

/* src/field_if.sv */
interface field_if
	import text_overlay_pkg::*;
();
	logic hit; // Pixel lies inside the block
	glyph_t glyph; // Glyph shown in the hit cell
	glyph_row_t row; // Row inside glyph, already scaled
	glyph_col_t col; // Column inside glyph, already scaled

	modport src
	(
		output hit,
		output glyph,
		output row,
		output col
	);

	modport sink
	(
		input hit,
		input glyph,
		input row,
		input col
	);
endinterface

/* src/clock_field.sv */
module clock_field
	import text_overlay_pkg::*;
(
	input coord_t pixel_x,
	input coord_t pixel_y,
	input bcd_t hour_tens,
	input bcd_t hour_units,
	input bcd_t min_tens,
	input bcd_t min_units,
	input bcd_t sec_tens,
	input bcd_t sec_units,
	input logic pm,
	field_if.src fld
);
	large_band_t lg_band;
	large_cell_t lg_cell;
	large_cell_t time_ofs;
	medium_band_t md_band;
	medium_cell_t md_cell;
	medium_cell_t ampm_ofs;
	logic time_hit;
	logic ampm_hit;
	glyph_t time_glyph;
	glyph_t ampm_glyph;

	assign lg_band = pixel_y[9:6]; // Large font grid
	assign lg_cell = pixel_x[9:5];
	assign md_band = pixel_y[9:5]; // Medium font grid
	assign md_cell = pixel_x[9:4];
	assign time_ofs = lg_cell - TIME_CELL_FIRST; // Cell inside the block
	assign ampm_ofs = md_cell - AMPM_CELL_FIRST;

	//////////////////////////////////////////////////
	// HH:MM:SS block
	//////////////////////////////////////////////////
	assign time_hit = (lg_band == TIME_BAND) && (lg_cell >= TIME_CELL_FIRST)
		&& (lg_cell < TIME_CELL_FIRST + TIME_CELLS);

	always_comb
	begin
		case (time_ofs[2:0])
			3'd0: time_glyph = digit_glyph(hour_tens);
			3'd1: time_glyph = digit_glyph(hour_units);
			3'd2: time_glyph = G_COLON;
			3'd3: time_glyph = digit_glyph(min_tens);
			3'd4: time_glyph = digit_glyph(min_units);
			3'd5: time_glyph = G_COLON;
			3'd6: time_glyph = digit_glyph(sec_tens);
			default: time_glyph = digit_glyph(sec_units);
		endcase
	end

	//////////////////////////////////////////////////
	// AM/PM tag
	//////////////////////////////////////////////////
	assign ampm_hit = (md_band == AMPM_BAND) && (md_cell >= AMPM_CELL_FIRST)
		&& (md_cell < AMPM_CELL_FIRST + AMPM_CELLS);
	assign ampm_glyph = ampm_ofs[0] ? G_M : (pm ? G_P : G_A); // A or P, then M

	// Bands never overlap, the time block just takes precedence
	assign fld.hit = time_hit | ampm_hit;
	assign fld.glyph = time_hit ? time_glyph : ampm_glyph;
	assign fld.row = time_hit ? pixel_y[5:2] : pixel_y[4:1]; // 4x or 2x scale
	assign fld.col = time_hit ? pixel_x[4:2] : pixel_x[3:1];

endmodule

/* src/date_field.sv */
module date_field
	import text_overlay_pkg::*;
(
	input coord_t pixel_x,
	input coord_t pixel_y,
	input bcd_t day_tens,
	input bcd_t day_units,
	input bcd_t month_tens,
	input bcd_t month_units,
	input bcd_t year_tens,
	input bcd_t year_units,
	input weekday_t weekday,
	field_if.src fld,
	output logic wday_hit
);
	medium_band_t md_band;
	medium_cell_t md_cell;
	medium_cell_t date_ofs;
	medium_cell_t wday_ofs;
	logic date_hit;
	glyph_t date_glyph;
	glyph_t wday_glyph;
	glyph_t [0:8] wday_text; // Nine cells, element 0 on the left

	assign md_band = pixel_y[9:5];
	assign md_cell = pixel_x[9:4];
	assign date_ofs = md_cell - DATE_CELL_FIRST;
	assign wday_ofs = md_cell - WDAY_CELL_FIRST;

	//////////////////////////////////////////////////
	// DD/MM/YY block
	//////////////////////////////////////////////////
	assign date_hit = (md_band == DATE_BAND) && (md_cell >= DATE_CELL_FIRST)
		&& (md_cell < DATE_CELL_FIRST + DATE_CELLS);

	always_comb
	begin
		case (date_ofs[2:0])
			3'd0: date_glyph = digit_glyph(day_tens);
			3'd1: date_glyph = digit_glyph(day_units);
			3'd2: date_glyph = G_SLASH;
			3'd3: date_glyph = digit_glyph(month_tens);
			3'd4: date_glyph = digit_glyph(month_units);
			3'd5: date_glyph = G_SLASH;
			3'd6: date_glyph = digit_glyph(year_tens);
			default: date_glyph = digit_glyph(year_units);
		endcase
	end

	//////////////////////////////////////////////////
	// Weekday name in Spanish
	//////////////////////////////////////////////////
	assign wday_hit = (md_band == WDAY_BAND) && (md_cell >= WDAY_CELL_FIRST)
		&& (md_cell < WDAY_CELL_FIRST + WDAY_CELLS);

	always_comb
	begin
		case (weekday)
			3'd0: wday_text = {G_L, G_U, G_N, G_E, G_S, G_BLANK, G_BLANK, G_BLANK, G_BLANK};
			3'd1: wday_text = {G_M, G_A, G_R, G_T, G_E, G_S, G_BLANK, G_BLANK, G_BLANK};
			3'd2: wday_text = {G_M, G_I, G_E, G_R, G_C, G_O, G_L, G_E, G_S};
			3'd3: wday_text = {G_J, G_U, G_E, G_V, G_E, G_S, G_BLANK, G_BLANK, G_BLANK};
			3'd4: wday_text = {G_V, G_I, G_E, G_R, G_N, G_E, G_S, G_BLANK, G_BLANK};
			3'd5: wday_text = {G_S, G_A, G_B, G_A, G_D, G_O, G_BLANK, G_BLANK, G_BLANK};
			3'd6: wday_text = {G_D, G_O, G_M, G_I, G_N, G_G, G_O, G_BLANK, G_BLANK};
			default: wday_text = {9{G_BLANK}}; // No weekday set
		endcase
	end

	// Cells past the name stay blank, keeps the index in range
	assign wday_glyph = (wday_ofs < WDAY_CELLS) ? wday_text[wday_ofs[3:0]] : G_BLANK;

	assign fld.hit = date_hit | wday_hit;
	assign fld.glyph = date_hit ? date_glyph : wday_glyph;
	assign fld.row = pixel_y[4:1]; // Both blocks at 2x scale
	assign fld.col = pixel_x[3:1];

	// Green selection downstream relies on one block at a time
	a_date_wday_excl: assert final (!(date_hit && wday_hit))
		else $error("date and weekday blocks hit on the same pixel");

endmodule

/* src/cursor_field.sv */
module cursor_field
	import text_overlay_pkg::*;
(
	input coord_t pixel_x,
	input coord_t pixel_y,
	input config_mode_t config_mode,
	input cursor_loc_t cursor_location,
	field_if.src fld
);
	medium_band_t md_band;
	medium_cell_t md_cell;
	medium_band_t cur_band; // Band for the active mode
	medium_cell_t pair_first; // Leftmost cell of selected pair
	medium_cell_t pair_cells;
	logic armed; // Mode and location both valid

	assign md_band = pixel_y[9:5];
	assign md_cell = pixel_x[9:4];

	always_comb
	begin
		armed = 1'b0;
		cur_band = CUR_TIME_BAND;
		pair_first = CUR_TIME_PAIR0;
		pair_cells = CUR_TIME_CELLS;
		case (config_mode)
			cfg_time:
			begin
				armed = (cursor_location != 2'd3);
				case (cursor_location)
					2'd1: pair_first = CUR_TIME_PAIR1; // Minutes
					2'd2: pair_first = CUR_TIME_PAIR2; // Hours
					default: pair_first = CUR_TIME_PAIR0; // Seconds
				endcase
			end
			cfg_date:
			begin
				armed = (cursor_location != 2'd3);
				cur_band = CUR_DATE_BAND;
				pair_cells = CUR_DATE_CELLS;
				case (cursor_location)
					2'd1: pair_first = CUR_DATE_PAIR1; // Month
					2'd2: pair_first = CUR_DATE_PAIR2; // Day
					default: pair_first = CUR_DATE_PAIR0; // Year
				endcase
			end
			default: armed = 1'b0; // Normal and code 3
		endcase
	end

	assign fld.hit = armed && (md_band == cur_band) && (md_cell >= pair_first)
		&& (md_cell < pair_first + pair_cells);
	assign fld.glyph = G_ARROW;
	assign fld.row = pixel_y[4:1];
	assign fld.col = pixel_x[3:1];

	a_cursor_mode: assert final (!fld.hit || (config_mode inside {cfg_time, cfg_date}))
		else $error("cursor drawn outside a configuration mode");

endmodule

/* src/glyph_select.sv */
module glyph_select
	import text_overlay_pkg::*;
(
	input logic clk,
	input logic rst_n,
	field_if.sink clk_fld,
	field_if.sink date_fld,
	field_if.sink cur_fld,
	input logic wday_hit,
	output glyph_t rom_glyph,
	output glyph_row_t rom_row,
	output logic sel_on,
	output glyph_col_t sel_col,
	output rgb_t sel_rgb
);
	logic nxt_on;
	glyph_t nxt_glyph;
	glyph_row_t nxt_row;
	glyph_col_t nxt_col;
	rgb_t nxt_rgb;

	//////////////////////////////////////////////////
	// Priority mux, clock then date then cursor
	//////////////////////////////////////////////////
	always_comb
	begin
		nxt_on = 1'b1;
		if (clk_fld.hit)
		begin
			nxt_glyph = clk_fld.glyph;
			nxt_row = clk_fld.row;
			nxt_col = clk_fld.col;
			nxt_rgb = COL_WHITE; // Time and AM/PM
		end
		else if (date_fld.hit)
		begin
			nxt_glyph = date_fld.glyph;
			nxt_row = date_fld.row;
			nxt_col = date_fld.col;
			nxt_rgb = wday_hit ? COL_GREEN : COL_WHITE;
		end
		else
		begin
			nxt_on = cur_fld.hit; // Background when cursor misses too
			nxt_glyph = cur_fld.glyph;
			nxt_row = cur_fld.row;
			nxt_col = cur_fld.col;
			nxt_rgb = COL_RED;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			sel_on <= 1'b0;
		else
			sel_on <= nxt_on;
	end

	always_ff @(posedge clk)
	begin
		rom_glyph <= nxt_glyph; // ROM address for next edge
		rom_row <= nxt_row;
		sel_col <= nxt_col;
		sel_rgb <= nxt_rgb;
	end

	// Field layouts are disjoint across all three decoders
	a_field_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({clk_fld.hit, date_fld.hit, cur_fld.hit}))
		else $error("overlapping text fields at one pixel");

endmodule

/* src/font_rom.sv */
module font_rom
	import text_overlay_pkg::*;
(
	input logic clk,
	input glyph_t glyph,
	input glyph_row_t row,
	output font_row_t font_row
);
	glyph_bits_t rom [GLYPH_COUNT]; // One 128 bit line per glyph

	initial
	begin
		$readmemh(GLYPH_FILE, rom);
	end

	// Row 0 is the top byte, so flip the row for the part select
	always_ff @(posedge clk)
	begin
		font_row <= rom[glyph][{~row, 3'b000} +: 8];
	end

endmodule

/* src/pixel_stage.sv */
module pixel_stage
	import text_overlay_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic sel_on,
	input glyph_col_t sel_col,
	input rgb_t sel_rgb,
	input font_row_t font_row,
	output logic text_on,
	output rgb_t text_rgb
);
	logic stg_on; // Lines up with font_row
	glyph_col_t stg_col;
	rgb_t stg_rgb;
	logic font_bit;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			stg_on <= 1'b0;
		else
			stg_on <= sel_on;
	end

	always_ff @(posedge clk)
	begin
		stg_col <= sel_col;
		stg_rgb <= sel_rgb;
	end

	assign font_bit = font_row[~stg_col]; // Column 0 is the MSB

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			text_on <= 1'b0;
			text_rgb <= '0;
		end
		else
		begin
			text_on <= stg_on;
			text_rgb <= (stg_on && font_bit) ? stg_rgb : '0; // Black off glyph
		end
	end

	a_rgb_needs_on: assert property (@(posedge clk) disable iff (!rst_n)
		(text_rgb != '0) |-> text_on)
		else $error("colour driven outside a text block");

endmodule

/* src/text_overlay_top.sv */
module text_overlay_top
	import text_overlay_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input bcd_t hour_tens, hour_units, min_tens, min_units, sec_tens, sec_units,
	input bcd_t day_tens, day_units, month_tens, month_units, year_tens, year_units,
	input logic pm,
	input weekday_t weekday,
	input config_mode_t config_mode,
	input cursor_loc_t cursor_location,
	input coord_t pixel_x,
	input coord_t pixel_y,
	output logic text_on,
	output rgb_t text_rgb
);
	field_if clk_fld();
	field_if date_fld();
	field_if cur_fld();

	logic wday_hit;
	glyph_t rom_glyph;
	glyph_row_t rom_row;
	logic sel_on;
	glyph_col_t sel_col;
	rgb_t sel_rgb;
	font_row_t font_row;

	//////////////////////////////////////////////////
	// Block decoders, all combinational
	//////////////////////////////////////////////////
	clock_field u_clock_field (
		.pixel_x(pixel_x), .pixel_y(pixel_y),
		.hour_tens(hour_tens), .hour_units(hour_units),
		.min_tens(min_tens), .min_units(min_units),
		.sec_tens(sec_tens), .sec_units(sec_units),
		.pm(pm), .fld(clk_fld.src)
	);

	date_field u_date_field (
		.pixel_x(pixel_x), .pixel_y(pixel_y),
		.day_tens(day_tens), .day_units(day_units),
		.month_tens(month_tens), .month_units(month_units),
		.year_tens(year_tens), .year_units(year_units),
		.weekday(weekday), .fld(date_fld.src), .wday_hit(wday_hit)
	);

	cursor_field u_cursor_field (
		.pixel_x(pixel_x), .pixel_y(pixel_y),
		.config_mode(config_mode), .cursor_location(cursor_location),
		.fld(cur_fld.src)
	);

	//////////////////////////////////////////////////
	// Three stage pixel pipeline
	//////////////////////////////////////////////////
	glyph_select u_glyph_select (
		.clk(clk), .rst_n(rst_n),
		.clk_fld(clk_fld.sink), .date_fld(date_fld.sink), .cur_fld(cur_fld.sink),
		.wday_hit(wday_hit),
		.rom_glyph(rom_glyph), .rom_row(rom_row),
		.sel_on(sel_on), .sel_col(sel_col), .sel_rgb(sel_rgb)
	);

	font_rom u_font_rom (
		.clk(clk), .glyph(rom_glyph), .row(rom_row), .font_row(font_row)
	);

	pixel_stage u_pixel_stage (
		.clk(clk), .rst_n(rst_n),
		.sel_on(sel_on), .sel_col(sel_col), .sel_rgb(sel_rgb),
		.font_row(font_row),
		.text_on(text_on), .text_rgb(text_rgb)
	);

endmodule

/* bench/text_overlay_tb.sv */
module text_overlay_tb
	import text_overlay_pkg::*;
();
	// Pixels per test, one per cycle
	localparam int TIME_PIXELS = (256 / 4) * (64 / 4);
	localparam int AMPM_PIXELS = 2 * (32 / 2) * (32 / 2);
	localparam int DATE_PIXELS = (128 / 2) * (32 / 2);
	localparam int WDAY_PIXELS = 8 * (144 / 2) * (32 / 8);
	localparam int CURSOR_PIXELS = 16 * 2 * (352 / 16) * (32 / 8);
	localparam int BG_PIXELS = 2000;
	localparam int TEST_CYCLES = TIME_PIXELS + AMPM_PIXELS + DATE_PIXELS
		+ WDAY_PIXELS + CURSOR_PIXELS + BG_PIXELS + 100; // Setup, drain, reset
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic clk = 1'b0;
	logic rst_n;
	bcd_t hour_tens, hour_units, min_tens, min_units, sec_tens, sec_units;
	bcd_t day_tens, day_units, month_tens, month_units, year_tens, year_units;
	logic pm;
	weekday_t weekday;
	config_mode_t config_mode;
	cursor_loc_t cursor_location;
	coord_t pixel_x;
	coord_t pixel_y;
	logic text_on;
	rgb_t text_rgb;

	glyph_bits_t font_tab [GLYPH_COUNT]; // Own copy of the glyph table
	logic [12:0] model_out; // {on, rgb} for the pixel sampled this edge
	logic [2:0] exp_on_q; // Model register then 2 deep delay line
	logic [2:0][11:0] exp_rgb_q;
	logic primed = 1'b0; // Outputs defined from the second edge on
	int since_reset = 0;
	int cycle_count = 0;
	int err_count = 0;
	int test_err_start = 0;
	int pass_tests = 0;
	int fail_tests = 0;

	text_overlay_top DUT (.*);

	always #4 clk = ~clk; // Period 8

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic glyph_t digit_code(input bcd_t d);
		return (d > 4'd9) ? G_BLANK : glyph_t'(d); // Above 9 is blank
	endfunction

	function automatic string day_name(input weekday_t wd);
		case (wd)
			3'd0: return "LUNES";
			3'd1: return "MARTES";
			3'd2: return "MIERCOLES";
			3'd3: return "JUEVES";
			3'd4: return "VIERNES";
			3'd5: return "SABADO";
			3'd6: return "DOMINGO";
			default: return ""; // All blank
		endcase
	endfunction

	function automatic glyph_t letter_code(input byte ch);
		case (ch)
			"A": return G_A;
			"B": return G_B;
			"C": return G_C;
			"D": return G_D;
			"E": return G_E;
			"G": return G_G;
			"I": return G_I;
			"J": return G_J;
			"L": return G_L;
			"M": return G_M;
			"N": return G_N;
			"O": return G_O;
			"R": return G_R;
			"S": return G_S;
			"T": return G_T;
			"U": return G_U;
			"V": return G_V;
			default: return G_BLANK;
		endcase
	endfunction

	function automatic logic cursor_hit(input coord_t x, input coord_t y);
		int band;
		int first;
		int cells;
		if (cursor_location == 2'd3)
			return 1'b0; // Cursor off
		if (config_mode == cfg_time)
		begin
			band = int'(CUR_TIME_BAND);
			cells = 4;
			first = (cursor_location == 2'd0) ? 26 : (cursor_location == 2'd1) ? 20 : 14;
		end
		else if (config_mode == cfg_date)
		begin
			band = int'(CUR_DATE_BAND);
			cells = 2;
			first = (cursor_location == 2'd0) ? 14 : (cursor_location == 2'd1) ? 11 : 8;
		end
		else
			return 1'b0; // Normal and code 3
		return (int'(y) / 32 == band) && (int'(x) / 16 >= first)
			&& (int'(x) / 16 < first + cells);
	endfunction

	function automatic logic [12:0] expect_pixel(input coord_t x, input coord_t y);
		int lc;
		int mb;
		int mc;
		int k;
		int row;
		int col;
		string name;
		glyph_t g;
		rgb_t colour;
		logic hit;
		logic lit;
		lc = int'(x) / 32;
		mb = int'(y) / 32;
		mc = int'(x) / 16;
		hit = 1'b1;
		g = G_BLANK;
		row = (int'(y) / 2) % 16; // Medium scale by default
		col = (int'(x) / 2) % 8;
		colour = COL_WHITE;
		if (int'(y) / 64 == int'(TIME_BAND) && lc >= int'(TIME_CELL_FIRST)
			&& lc < int'(TIME_CELL_FIRST) + 8)
		begin
			k = lc - int'(TIME_CELL_FIRST);
			case (k)
				0: g = digit_code(hour_tens);
				1: g = digit_code(hour_units);
				3: g = digit_code(min_tens);
				4: g = digit_code(min_units);
				6: g = digit_code(sec_tens);
				7: g = digit_code(sec_units);
				default: g = G_COLON;
			endcase
			row = (int'(y) / 4) % 16; // Large scale
			col = (int'(x) / 4) % 8;
		end
		else if (mb == int'(AMPM_BAND) && mc >= 26 && mc < 28)
			g = (mc == 26) ? (pm ? G_P : G_A) : G_M;
		else if (mb == int'(DATE_BAND) && mc >= 8 && mc < 16)
		begin
			case (mc - 8)
				0: g = digit_code(day_tens);
				1: g = digit_code(day_units);
				3: g = digit_code(month_tens);
				4: g = digit_code(month_units);
				6: g = digit_code(year_tens);
				7: g = digit_code(year_units);
				default: g = G_SLASH;
			endcase
		end
		else if (mb == int'(WDAY_BAND) && mc >= 8 && mc < 17)
		begin
			k = mc - 8;
			name = day_name(weekday);
			g = (k < name.len()) ? letter_code(name[k]) : G_BLANK; // Padded name
			colour = COL_GREEN;
		end
		else if (cursor_hit(x, y))
		begin
			g = G_ARROW;
			colour = COL_RED;
		end
		else
			hit = 1'b0;
		lit = font_tab[g][127 - 8 * row - col]; // Row 0 top byte, col 0 MSB
		return {hit, (hit && lit) ? colour : 12'h000};
	endfunction

	always @(posedge clk)
	begin
		primed <= 1'b1;
		cycle_count <= cycle_count + 1;
		if (!rst_n)
		begin
			since_reset <= 0;
			exp_on_q <= '0;
			exp_rgb_q <= '0;
		end
		else
		begin
			if (since_reset < 3)
				since_reset <= since_reset + 1;
			model_out = expect_pixel(pixel_x, pixel_y); // Inputs the DUT samples now
			exp_on_q <= {exp_on_q[1:0], model_out[12]};
			exp_rgb_q <= {exp_rgb_q[1:0], model_out[11:0]};
		end
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("sim failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////
	a_reset_quiet: assert property (@(posedge clk)
		(primed && since_reset < 3) |-> (text_on === 1'b0 && text_rgb === 12'h000))
		else
		begin
			err_count++;
			$display("Fail %0t: output active during or right after reset", $time);
		end

	a_pixel_match: assert property (@(posedge clk)
		primed |-> (text_on === exp_on_q[2] && text_rgb === exp_rgb_q[2]))
		else
		begin
			err_count++;
			$display("Fail %0t: got on %b rgb %h, expected on %b rgb %h", $time,
				$sampled(text_on), $sampled(text_rgb),
				$sampled(exp_on_q[2]), $sampled(exp_rgb_q[2]));
		end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	task automatic drive_pixel(input int x, input int y);
		@(posedge clk);
		pixel_x <= coord_t'(x);
		pixel_y <= coord_t'(y);
	endtask

	// One random pixel inside each sx by sy tile
	task automatic scan_area(input int x0, input int y0, input int w, input int h,
		input int sx, input int sy);
		int xi;
		int yi;
		for (yi = 0; yi < h / sy; yi++)
			for (xi = 0; xi < w / sx; xi++)
				drive_pixel(x0 + xi * sx + int'($urandom % sx), y0 + yi * sy + int'($urandom % sy));
	endtask

	task automatic random_time();
		hour_tens <= bcd_t'($urandom);
		hour_units <= bcd_t'($urandom);
		min_tens <= bcd_t'($urandom);
		min_units <= bcd_t'($urandom);
		sec_tens <= bcd_t'($urandom);
		sec_units <= bcd_t'($urandom);
	endtask

	task automatic random_date();
		day_tens <= bcd_t'($urandom);
		day_units <= bcd_t'($urandom);
		month_tens <= bcd_t'($urandom);
		month_units <= bcd_t'($urandom);
		year_tens <= bcd_t'($urandom);
		year_units <= bcd_t'($urandom);
	endtask

	task automatic end_test(input string name);
		int errs;
		repeat (4) drive_pixel(0, 0); // Drain with background
		@(negedge clk); // Last check has landed
		errs = err_count - test_err_start;
		if (errs == 0)
		begin
			pass_tests++;
			$display("test %s: ok", name);
		end
		else
		begin
			fail_tests++;
			$display("test %s: %0d errors", name, errs);
		end
		test_err_start = err_count;
	endtask

	initial
	begin
		void'($urandom(87));
		$readmemh(GLYPH_FILE, font_tab);
		rst_n = 1'b0;
		random_time();
		random_date();
		pm = 1'b0;
		weekday = 3'd7;
		config_mode = cfg_normal;
		cursor_location = 2'd3;
		pixel_x = 10'd300; // Lit colon pixel held through reset
		pixel_y = 10'd146;

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		end_test("reset");

		@(posedge clk);
		random_time();
		scan_area(int'(TIME_CELL_FIRST) * 32, int'(TIME_BAND) * 64, 256, 64, 4, 4);
		end_test("time_digits");

		for (int p = 0; p < 2; p++)
		begin
			@(posedge clk);
			pm <= 1'(p);
			scan_area(int'(AMPM_CELL_FIRST) * 16, int'(AMPM_BAND) * 32, 32, 32, 2, 2);
		end
		end_test("am_pm");

		@(posedge clk);
		random_date();
		scan_area(int'(DATE_CELL_FIRST) * 16, int'(DATE_BAND) * 32, 128, 32, 2, 2);
		for (int wd = 0; wd < 8; wd++)
		begin
			@(posedge clk);
			weekday <= weekday_t'(wd);
			scan_area(int'(WDAY_CELL_FIRST) * 16, int'(WDAY_BAND) * 32, 144, 32, 2, 8);
		end
		end_test("date_weekday");

		for (int m = 0; m < 4; m++)
			for (int loc = 0; loc < 4; loc++)
			begin
				@(posedge clk);
				config_mode <= config_mode_t'(m);
				cursor_location <= cursor_loc_t'(loc);
				scan_area(128, int'(CUR_TIME_BAND) * 32, 352, 32, 16, 8);
				scan_area(128, int'(CUR_DATE_BAND) * 32, 352, 32, 16, 8);
			end
		end_test("cursor");

		repeat (BG_PIXELS)
		begin
			@(posedge clk); // Everything changes every cycle
			random_time();
			random_date();
			pm <= 1'($urandom);
			weekday <= weekday_t'($urandom);
			config_mode <= config_mode_t'($urandom % 4);
			cursor_location <= cursor_loc_t'($urandom);
			pixel_x <= coord_t'($urandom % 640);
			pixel_y <= coord_t'($urandom % 480);
		end
		end_test("background");

		$display("tests passed %0d, failed %0d", pass_tests, fail_tests);
		if (fail_tests == 0 && err_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* src/glyphs.mem */
// One glyph per line as 32 hex digits, glyph code 0 on the first data line
// Leftmost byte is glyph row 0 at the top, MSB of each byte is the leftmost pixel
00007CC6C6CEDEF6E6C6C67C00000000
00001838781818181818187E00000000
00007CC6060C183060C0C6FE00000000
00007CC606063C060606C67C00000000
00000C1C3C6CCCFE0C0C0C1E00000000
0000FEC0C0C0FC060606C67C00000000
00003860C0C0FCC6C6C6C67C00000000
0000FEC606060C183030303000000000
00007CC6C6C67CC6C6C6C67C00000000
00007CC6C6C67E0606060C7800000000
00000000181800000018180000000000
0000000002060C183060C08000000000
00000000000000000000000000000000
000010387CFE38383838383800000000
000010386CC6C6FEC6C6C6C600000000
0000FC6666667C66666666FC00000000
00003C66C2C0C0C0C0C2663C00000000
0000F86C6666666666666CF800000000
0000FE6662687868606266FE00000000
00003C66C2C0C0DEC6C6663A00000000
00003C18181818181818183C00000000
00001E0C0C0C0C0CCCCCCC7800000000
0000F06060606060606266FE00000000
0000C6EEFEFED6C6C6C6C6C600000000
0000C6E6F6FEDECEC6C6C6C600000000
00007CC6C6C6C6C6C6C6C67C00000000
0000FC6666667C60606060F000000000
0000FC6666667C6C666666E600000000
00007CC6C660380C06C6C67C00000000
0000FFDB991818181818183C00000000
0000C6C6C6C6C6C6C6C6C67C00000000
0000C6C6C6C6C6C6C66C381000000000

/* text_overlay.f */
src/text_overlay_pkg.sv
src/field_if.sv
src/clock_field.sv
src/date_field.sv
src/cursor_field.sv
src/glyph_select.sv
src/font_rom.sv
src/pixel_stage.sv
src/text_overlay_top.sv
bench/text_overlay_tb.sv

/* Bender.yml */
package:
  name: text_overlay

sources:
  - src/text_overlay_pkg.sv
  - src/field_if.sv
  - src/clock_field.sv
  - src/date_field.sv
  - src/cursor_field.sv
  - src/glyph_select.sv
  - src/font_rom.sv
  - src/pixel_stage.sv
  - src/text_overlay_top.sv
  - target: test
    files:
      - bench/text_overlay_tb.sv
